// ==== sim.f ====
+incdir+.
fb_pkg.sv
display_timing_if.sv
display_timings.sv
bram_sdp.sv
fb_scan_ctrl.sv
video_output.sv
fb_display_top.sv
tb_fb_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the framebuffer display testbench with Verilator and run it
# the run counts as passed only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fb_display -f sim.f \
    && ./obj_dir/Vtb_fb_display | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "verilator run: pass" \
    || { echo "verilator run: fail"; exit 1; }

// ==== tb_fb_display.sv ====
/* Framebuffer display testbench
   Random host writes checked against a cycle model of timing, framebuffer and palette */

`timescale 1ns/100ps
`default_nettype none

`include "fb_config.svh"

module tb_fb_display import fb_pkg::*; ();

    localparam int SEED          = 52045;
    localparam int CLK_PERIOD_NS = 20;
    localparam int FRAME_CYCLES  = `H_TOTAL * `V_TOTAL;
    localparam int RUN_FRAMES    = 3;
    localparam int WATCHDOG_NS   = 4 * FRAME_CYCLES * CLK_PERIOD_NS;

    // pixel after the framebuffer read, palette read still pending
    typedef struct packed {
        logic       is_idle;    // reset content of the pipeline
        logic       hs;
        logic       vs;
        logic       act;        // inside the framebuffer window
        logic       idx_known;  // framebuffer word was written
        logic [3:0] idx;
        logic [9:0] x;
        logic [9:0] y;
    } fetch_t;

    // expected state of the pins
    typedef struct packed {
        logic        is_idle;
        logic        hs;
        logic        vs;
        logic        rgb_known;
        logic [11:0] rgb;
        logic [9:0]  x;
        logic [9:0]  y;
    } pin_t;

    logic       clk_pix;
    logic       rst_n;
    logic       fb_we;
    fb_addr_t   fb_waddr;
    colr_idx_t  fb_wdata;
    logic       pal_we;
    pal_addr_t  pal_waddr;
    rgb_t       pal_wdata;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    colr_idx_t fb_model  [`FB_PIXELS];     // shadow framebuffer
    bit        fb_known  [`FB_PIXELS];     // set once written
    rgb_t      pal_model [`PAL_ENTRIES];   // shadow palette
    bit        pal_known [`PAL_ENTRIES];

    int     mx;             // model position of the current cycle
    int     my;
    fetch_t stage;          // one pixel between the two memory reads
    pin_t   exp_q [$];      // pins still to come

    fb_display_top i_dut (
        .clk_pix,
        .rst_n,
        .fb_we,
        .fb_waddr,
        .fb_wdata,
        .pal_we,
        .pal_waddr,
        .pal_wdata,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_pix = ~clk_pix;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // sync rules and framebuffer read for one position
    function automatic fetch_t fetch_pixel(input int x, input int y);
        fetch_t f;
        int     addr;
        f.is_idle   = 1'b0;
        f.x         = 10'(x);
        f.y         = 10'(y);
        f.hs        = !(x >= `H_SYNC_START && x <= `H_SYNC_END);  // active low
        f.vs        = !(y >= `V_SYNC_START && y <= `V_SYNC_END);
        f.act       = (x < `FB_WIDTH) && (y < `FB_HEIGHT);
        f.idx       = 4'h0;
        f.idx_known = 1'b1;
        if (f.act) begin
            addr        = y * `FB_WIDTH + x;  // raster order
            f.idx       = fb_model[addr];
            f.idx_known = fb_known[addr];
        end
        return f;
    endfunction

    // palette read, black outside the window
    function automatic pin_t resolve_colour(input fetch_t f);
        pin_t p;
        p.is_idle   = f.is_idle;
        p.hs        = f.hs;
        p.vs        = f.vs;
        p.x         = f.x;
        p.y         = f.y;
        p.rgb       = 12'h000;
        p.rgb_known = 1'b1;
        if (f.act) begin
            p.rgb       = pal_model[f.idx];
            p.rgb_known = f.idx_known && pal_known[f.idx];
        end
        return p;
    endfunction

    function automatic pin_t idle_pins();
        pin_t p;
        p           = '0;
        p.is_idle   = 1'b1;
        p.hs        = 1'b1;
        p.vs        = 1'b1;
        p.rgb_known = 1'b1;
        return p;
    endfunction

    task automatic check_pins();
        pin_t  e;
        string where;
        if (exp_q.size() == 0) begin
            $display("model error: no expected pin state left in the queue");
            abort_run();
        end
        e     = exp_q.pop_front();
        where = e.is_idle ? "reset state" : $sformatf("pixel (%0d,%0d)", e.x, e.y);
        check_equal({where, " hsync"}, 32'(vga_hsync), 32'(e.hs));
        check_equal({where, " vsync"}, 32'(vga_vsync), 32'(e.vs));
        if (e.rgb_known) begin  // unwritten memory is not checked
            check_equal({where, " colour"}, 32'({vga_r, vga_g, vga_b}), 32'(e.rgb));
        end
    endtask

    // host writes of one cycle, shadows updated after this cycle's reads
    task automatic host_writes(input int cyc, input bit rd_act, input int rd_addr,
                               input colr_idx_t pal_rd_idx);
        logic [31:0] r;
        logic [31:0] r2;
        r      = $urandom;
        r2     = $urandom;
        fb_we  = 1'b0;
        pal_we = 1'b0;
        if (cyc < `PAL_ENTRIES) begin
            pal_we    = 1'b1;                     // palette fill
            pal_waddr = pal_addr_t'(cyc);
            pal_wdata = rgb_t'(r2[11:0]);
        end else if (cyc < `PAL_ENTRIES + `FB_PIXELS) begin
            fb_we    = 1'b1;                      // whole framebuffer in order
            fb_waddr = fb_addr_t'(cyc - `PAL_ENTRIES);
            fb_wdata = colr_idx_t'(r[3:0]);
        end else if (cyc >= FRAME_CYCLES) begin
            if (r[5:0] == 6'd0) begin             // sparse pixel writes
                fb_we    = 1'b1;
                fb_waddr = (r[6] && rd_act) ? fb_addr_t'(rd_addr)  // collide with the read
                         : fb_addr_t'($urandom_range(`FB_PIXELS - 1));
                fb_wdata = colr_idx_t'(r[19:16]);
            end
            if (r[14:7] == 8'd0) begin            // rarer palette writes
                pal_we    = 1'b1;
                pal_waddr = r[15] ? pal_rd_idx : pal_addr_t'(r[23:20]);
                pal_wdata = rgb_t'(r2[11:0]);
            end
        end
        if (fb_we) begin
            fb_model[fb_waddr] = fb_wdata;
            fb_known[fb_waddr] = 1'b1;
        end
        if (pal_we) begin
            pal_model[pal_waddr] = pal_wdata;
            pal_known[pal_waddr] = 1'b1;
        end
    endtask

    task automatic run_cycle(input int cyc);
        fetch_t next;
        check_pins();
        next = fetch_pixel(mx, my);                 // framebuffer read at the end of this cycle
        exp_q.push_back(resolve_colour(stage));     // palette read at the end of this cycle
        host_writes(cyc, next.act, my * `FB_WIDTH + mx, colr_idx_t'(stage.idx));
        stage = next;
        mx++;
        if (mx == `H_TOTAL) begin
            mx = 0;
            my = (my == `V_TOTAL - 1) ? 0 : my + 1;  // next frame restarts at address 0
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        fb_we     = 1'b0;
        fb_waddr  = '0;
        fb_wdata  = '0;
        pal_we    = 1'b0;
        pal_waddr = '0;
        pal_wdata = '0;
        mx        = 0;
        my        = 0;
        stage     = '0;
        stage.is_idle = 1'b1;  // delay line resets to idle syncs, inactive
        stage.hs      = 1'b1;
        stage.vs      = 1'b1;
        exp_q.push_back(idle_pins());  // output regs still in reset
        exp_q.push_back(idle_pins());
        repeat (3) begin
            @(posedge clk_pix);
            #2;
            check_equal("hsync in reset", 32'(vga_hsync), 32'd1);
            check_equal("vsync in reset", 32'(vga_vsync), 32'd1);
            check_equal("colour in reset", 32'({vga_r, vga_g, vga_b}), 32'd0);
        end
        rst_n = 1'b1;  // cycle 0 holds position (0,0)
        for (int cyc = 0; cyc < RUN_FRAMES * FRAME_CYCLES; cyc++) begin
            run_cycle(cyc);
            @(posedge clk_pix);
            #2;
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // three frames plus reset fit well inside four frame times
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== fb_display_top.sv ====
/* Framebuffer display top level
   Timing generator, scan control, framebuffer, palette and output registers
   with host write ports for both memories */

`timescale 1ns/100ps
`default_nettype none

`include "fb_config.svh"

module fb_display_top import fb_pkg::*; (
    input  wire logic      clk_pix,
    input  wire logic      rst_n,
    // host pixel writes
    input  wire logic      fb_we,
    input  wire fb_addr_t  fb_waddr,
    input  wire colr_idx_t fb_wdata,
    // host palette writes
    input  wire logic      pal_we,
    input  wire pal_addr_t pal_waddr,
    input  wire rgb_t      pal_wdata,
    // display pins
    output      logic       vga_hsync,
    output      logic       vga_vsync,
    output      logic [3:0] vga_r,
    output      logic [3:0] vga_g,
    output      logic [3:0] vga_b
);

    fb_addr_t  fb_raddr;    // cycle 0
    colr_idx_t colr_idx;    // cycle 1
    rgb_t      pix;         // cycle 2
    logic      hsync_d;
    logic      vsync_d;
    logic      active_d;

    display_timing_if tim ();

    display_timings i_timings (
        .clk_pix,
        .rst_n,
        .tim    (tim.source)
    );

    fb_scan_ctrl i_scan (
        .clk_pix,
        .rst_n,
        .tim      (tim.sink),
        .rd_addr  (fb_raddr),
        .hsync_d,
        .vsync_d,
        .active_d
    );

    // 160x120 colour indices
    bram_sdp #(
        .payload_t (colr_idx_t),
        .DEPTH     (`FB_PIXELS)
    ) i_framebuffer (
        .clk_pix,
        .we    (fb_we),
        .waddr (fb_waddr),
        .raddr (fb_raddr),
        .wdata (fb_wdata),
        .rdata (colr_idx)
    );

    // colour table indexed straight by the framebuffer word
    bram_sdp #(
        .payload_t (rgb_t),
        .DEPTH     (`PAL_ENTRIES)
    ) i_palette (
        .clk_pix,
        .we    (pal_we),
        .waddr (pal_waddr),
        .raddr (colr_idx),
        .wdata (pal_wdata),
        .rdata (pix)
    );

    video_output i_video_out (
        .clk_pix,
        .rst_n,
        .pix,
        .hsync_in (hsync_d),
        .vsync_in (vsync_d),
        .active   (active_d),
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

endmodule

`default_nettype wire

// ==== video_output.sv ====
/* Video output stage
   Registers the sync pins and the colour channels, black outside the window */

`timescale 1ns/100ps
`default_nettype none

module video_output import fb_pkg::*; (
    input  wire logic       clk_pix,
    input  wire logic       rst_n,
    input  wire rgb_t       pix,        // palette read data
    input  wire logic       hsync_in,
    input  wire logic       vsync_in,
    input  wire logic       active,     // pix is a framebuffer pixel
    output      logic       vga_hsync,
    output      logic       vga_vsync,
    output      logic [3:0] vga_r,
    output      logic [3:0] vga_g,
    output      logic [3:0] vga_b
);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;  // idle sync
            vga_vsync <= 1'b1;
            vga_r     <= 4'h0;  // black
            vga_g     <= 4'h0;
            vga_b     <= 4'h0;
        end else begin
            vga_hsync <= hsync_in;
            vga_vsync <= vsync_in;
            // blanking and the area right of or below the framebuffer are black
            vga_r     <= active ? pix.red   : 4'h0;
            vga_g     <= active ? pix.green : 4'h0;
            vga_b     <= active ? pix.blue  : 4'h0;
        end
    end

endmodule

`default_nettype wire

// ==== fb_scan_ctrl.sv ====
/* Framebuffer scan control
   Raster read address for the framebuffer window and sync/active delay line
   matching the two-stage memory pipeline */

`timescale 1ns/100ps
`default_nettype none

`include "fb_config.svh"

module fb_scan_ctrl import fb_pkg::*; (
    input  wire logic       clk_pix,
    input  wire logic       rst_n,
    display_timing_if.sink  tim,
    output      fb_addr_t   rd_addr,   // same cycle as the position
    output      logic       hsync_d,   // two cycles late
    output      logic       vsync_d,
    output      logic       active_d
);

    logic     fb_active;    // position inside the framebuffer window
    fb_addr_t addr_cnt;     // raster address of the current position
    logic [1:0] hsync_sr;   // bit 1 is the older stage
    logic [1:0] vsync_sr;
    logic [1:0] active_sr;

    // window is the top-left FB_WIDTH x FB_HEIGHT of the visible area
    always_comb begin
        fb_active = tim.de
                 && (tim.sx < `FB_WIDTH)
                 && (tim.sy < `FB_HEIGHT);
    end

    // address counter
    // restarts on the last pixel so the next frame opens at zero
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
        end else if (tim.frame_end) begin
            addr_cnt <= '0;
        end else if (fb_active) begin
            addr_cnt <= addr_cnt + 1'b1;  // y*160 + x
        end
    end

    assign rd_addr = addr_cnt;  // read issued with the position

    // delay line
    // framebuffer read then palette read so two stages
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_sr  <= 2'b11;  // inactive sync level
            vsync_sr  <= 2'b11;
            active_sr <= 2'b00;
        end else begin
            hsync_sr  <= {hsync_sr[0], tim.hsync};
            vsync_sr  <= {vsync_sr[0], tim.vsync};
            active_sr <= {active_sr[0], fb_active};
        end
    end

    assign hsync_d  = hsync_sr[1];
    assign vsync_d  = vsync_sr[1];
    assign active_d = active_sr[1];

    // counter stays inside the framebuffer over the whole window
    a_addr_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        fb_active |-> (rd_addr < `FB_PIXELS)
    ) else $error("framebuffer address %0d out of range", rd_addr);

    // window start of each line lands on a multiple of the width
    a_line_start: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (fb_active && tim.sx == '0) |-> (rd_addr == tim.sy * `FB_WIDTH)
    ) else $error("line %0d starts at address %0d", tim.sy, rd_addr);

endmodule

`default_nettype wire

// ==== bram_sdp.sv ====
/* Simple dual-port memory
   One write port and one registered read port, payload set by type */

`timescale 1ns/100ps
`default_nettype none

module bram_sdp #(
    parameter type payload_t = logic [7:0],  // stored word
    parameter int  DEPTH     = 16            // number of words
) (
    input  wire logic                     clk_pix,
    input  wire logic                     we,     // write strobe
    input  wire logic [$clog2(DEPTH)-1:0] waddr,
    input  wire logic [$clog2(DEPTH)-1:0] raddr,
    input  wire payload_t                 wdata,
    output      payload_t                 rdata   // one cycle after raddr
);

    payload_t mem [DEPTH];  // contents unknown until written

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port sees the array before this edge's write
    // so a same-address collision returns the old word
    always_ff @(posedge clk_pix) begin
        rdata <= mem[raddr];
    end

    // host must stay inside the array
    a_waddr_range: assert property (
        @(posedge clk_pix)
        we |-> (waddr < DEPTH)
    ) else $error("write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

// ==== display_timings.sv ====
/* Display timings
   Scans an 800x525 frame one pixel per clock with registered syncs and enables */

`timescale 1ns/100ps
`default_nettype none

`include "fb_config.svh"

module display_timings import fb_pkg::*; (
    input  wire logic       clk_pix,
    input  wire logic       rst_n,
    display_timing_if.source tim
);

    coord_t sx_next;    // position for the next clock
    coord_t sy_next;
    logic   line_end;   // last column of a line
    logic   last_line;  // last line of the frame

    always_comb begin
        line_end  = (tim.sx == coord_t'(`H_TOTAL - 1));
        last_line = (tim.sy == coord_t'(`V_TOTAL - 1));
        sx_next   = line_end ? '0 : tim.sx + 1'b1;
        sy_next   = tim.sy;
        if (line_end) begin
            sy_next = last_line ? '0 : tim.sy + 1'b1;  // wrap at frame end
        end
    end

    // all outputs are decoded from the next position and registered together
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            tim.sx        <= '0;
            tim.sy        <= '0;
            tim.hsync     <= 1'b1;  // syncs idle high
            tim.vsync     <= 1'b1;
            tim.de        <= 1'b1;  // (0,0) is visible
            tim.frame_end <= 1'b0;
        end else begin
            tim.sx        <= sx_next;
            tim.sy        <= sy_next;
            tim.hsync     <= ~(sx_next >= `H_SYNC_START && sx_next <= `H_SYNC_END);
            tim.vsync     <= ~(sy_next >= `V_SYNC_START && sy_next <= `V_SYNC_END);
            tim.de        <= (sx_next < `H_RES) && (sy_next < `V_RES);
            tim.frame_end <= (sx_next == coord_t'(`H_TOTAL - 1))
                          && (sy_next == coord_t'(`V_TOTAL - 1));
        end
    end

    // position never leaves the frame
    a_pos_in_frame: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (tim.sx < `H_TOTAL) && (tim.sy < `V_TOTAL)
    ) else $error("scan position outside the frame");

    // frame_end marks the last pixel and is followed by the origin
    a_frame_wrap: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        tim.frame_end |=> (tim.sx == '0) && (tim.sy == '0)
    ) else $error("frame did not wrap to the origin");

endmodule

`default_nettype wire

// ==== display_timing_if.sv ====
/* Display timing bundle
   Scan position, syncs, data enable and last-pixel flag of the raster */

`timescale 1ns/100ps
`default_nettype none

interface display_timing_if import fb_pkg::*; ();

    coord_t sx;         // column
    coord_t sy;         // line
    logic   hsync;      // active low
    logic   vsync;      // active low
    logic   de;         // visible area
    logic   frame_end;  // last pixel of the frame

    // timing generator side
    modport source (
        output sx, sy, hsync, vsync, de, frame_end
    );

    // consumer side
    modport sink (
        input sx, sy, hsync, vsync, de, frame_end
    );

endinterface

`default_nettype wire

// ==== fb_pkg.sv ====
/* Framebuffer display types
   Coordinates, memory addresses, colour index and 12-bit RGB colour */

`default_nettype none

`include "fb_config.svh"

package fb_pkg;

    // screen coordinate wide enough for 800 columns
    typedef logic [9:0] coord_t;

    // framebuffer word address
    typedef logic [$clog2(`FB_PIXELS)-1:0] fb_addr_t;

    // pixel payload in the framebuffer
    typedef logic [3:0] colr_idx_t;

    // colour table address
    typedef logic [$clog2(`PAL_ENTRIES)-1:0] pal_addr_t;

    // colour table payload, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

// ==== fb_config.svh ====
/* Framebuffer display configuration
   Screen, blanking, sync and framebuffer geometry for a 640x480 raster */

`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// visible area
`define H_RES           640
`define V_RES           480

// full frame with blanking
`define H_TOTAL         800
`define V_TOTAL         525

// sync pulses as first and last column or line
`define H_SYNC_START    656
`define H_SYNC_END      751
`define V_SYNC_START    490
`define V_SYNC_END      491

// framebuffer in the top-left corner of the screen
`define FB_WIDTH        160
`define FB_HEIGHT       120
`define FB_PIXELS       19200   // FB_WIDTH * FB_HEIGHT

// colour table size
`define PAL_ENTRIES     16

`endif
